//--- common/window_cfg_pkg.sv
package window_cfg_pkg;

    // datapath width
    localparam int data_width = 32;

    // 64 physical registers
    localparam int tag_width = 6;

    typedef logic [data_width-1:0] data_t;
    typedef logic [tag_width-1:0]  tag_t;

endpackage

//--- common/alu_ops_pkg.sv
package alu_ops_pkg;

    // integer alu operations, risc-v semantics
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_t;

    // second source field, read as an immediate word or as a register tag
    typedef union packed {
        window_cfg_pkg::data_t imm;
        struct packed {
            logic [window_cfg_pkg::data_width-window_cfg_pkg::tag_width-1:0] pad;
            window_cfg_pkg::tag_t                                             tag;
        } rf;
    } src2_u;

endpackage

//--- issue_window/dispatch_unit.sv
`timescale 1ns/1ns

module dispatch_unit #(
    parameter int num_entries = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   dispatch_valid,
    input  alu_ops_pkg::alu_op_t   dispatch_op,
    input  window_cfg_pkg::tag_t   dispatch_dest,
    input  window_cfg_pkg::tag_t   dispatch_src1,
    input  alu_ops_pkg::src2_u     dispatch_src2,
    input  logic                   dispatch_src2_is_imm,
    input  logic                   src1_ready,
    input  logic                   src2_ready,
    input  logic                   result_valid,
    input  window_cfg_pkg::tag_t   result_tag,
    input  logic [num_entries-1:0] entry_busy,
    output window_cfg_pkg::tag_t   rd_tag1,
    output window_cfg_pkg::tag_t   rd_tag2,
    output logic                   clear_ready,
    output logic [num_entries-1:0] fill_sel,
    output alu_ops_pkg::alu_op_t   fill_op,
    output window_cfg_pkg::tag_t   fill_dest,
    output window_cfg_pkg::tag_t   fill_src1,
    output alu_ops_pkg::src2_u     fill_src2,
    output logic                   fill_src2_is_imm,
    output logic                   fill_rdy1,
    output logic                   fill_rdy2,
    output logic                   window_full
);

    logic [num_entries-1:0] free_sel;
    logic                   accept;
    logic                   hit1;
    logic                   hit2;

    // lowest clear bit of the busy vector, zero when all busy
    assign free_sel    = ~entry_busy & (entry_busy + 1'b1);
    assign window_full = &entry_busy;
    assign accept      = dispatch_valid && !window_full;

    assign fill_sel    = accept ? free_sel : '0;
    assign clear_ready = accept; // new producer pending on dest

    // readiness lookup for both sources
    assign rd_tag1 = dispatch_src1;
    assign rd_tag2 = dispatch_src2.rf.tag;

    // result written this edge is not yet visible in the ready bits
    assign hit1 = result_valid && (result_tag == dispatch_src1);
    assign hit2 = result_valid && (result_tag == dispatch_src2.rf.tag);

    assign fill_rdy1 = src1_ready || hit1;
    assign fill_rdy2 = dispatch_src2_is_imm || src2_ready || hit2;

    assign fill_op          = dispatch_op;
    assign fill_dest        = dispatch_dest;
    assign fill_src1        = dispatch_src1;
    assign fill_src2        = dispatch_src2;
    assign fill_src2_is_imm = dispatch_src2_is_imm;

    // source must hold off while full, no back-pressure otherwise
    a_no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (reset) dispatch_valid |-> !window_full
    );

endmodule

//--- issue_window/rs_entry.sv
`timescale 1ns/1ns

module rs_entry (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fill,
    input  alu_ops_pkg::alu_op_t fill_op,
    input  window_cfg_pkg::tag_t fill_dest,
    input  window_cfg_pkg::tag_t fill_src1,
    input  alu_ops_pkg::src2_u   fill_src2,
    input  logic                 fill_src2_is_imm,
    input  logic                 fill_rdy1,
    input  logic                 fill_rdy2,
    input  logic                 result_valid,
    input  window_cfg_pkg::tag_t result_tag,
    input  logic                 grant,
    output logic                 busy,
    output logic                 request,
    output alu_ops_pkg::alu_op_t op,
    output window_cfg_pkg::tag_t dest,
    output window_cfg_pkg::tag_t src1,
    output alu_ops_pkg::src2_u   src2,
    output logic                 src2_is_imm
);

    logic rdy1;
    logic rdy2;
    logic wake1;
    logic wake2;

    // broadcast match on the waiting tags
    assign wake1 = result_valid && (result_tag == src1);
    assign wake2 = result_valid && (result_tag == src2.rf.tag);

    assign request = busy && rdy1 && rdy2;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            rdy1 <= 1'b0;
            rdy2 <= 1'b0;
        end else if (fill) begin
            busy <= 1'b1;
            rdy1 <= fill_rdy1;
            rdy2 <= fill_rdy2;
        end else if (busy) begin
            if (grant) begin
                busy <= 1'b0; // slot free next cycle
            end
            if (wake1) begin
                rdy1 <= 1'b1;
            end
            if (wake2) begin
                rdy2 <= 1'b1; // already set for immediates
            end
        end
    end

    // operation payload
    always_ff @(posedge clk) begin
        if (fill) begin
            op          <= fill_op;
            dest        <= fill_dest;
            src1        <= fill_src1;
            src2        <= fill_src2;
            src2_is_imm <= fill_src2_is_imm;
        end
    end

    // dispatch only targets empty slots
    a_fill_when_free: assert property (
        @(posedge clk) disable iff (reset) fill |-> !busy
    );

endmodule

//--- issue_window/issue_select.sv
`timescale 1ns/1ns

module issue_select #(
    parameter int num_entries = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [num_entries-1:0] request,
    input  alu_ops_pkg::alu_op_t   op [num_entries],
    input  window_cfg_pkg::tag_t   dest [num_entries],
    input  window_cfg_pkg::tag_t   src1 [num_entries],
    input  alu_ops_pkg::src2_u     src2 [num_entries],
    input  logic [num_entries-1:0] src2_is_imm,
    output logic [num_entries-1:0] grant,
    output window_cfg_pkg::tag_t   rd_tag1,
    output window_cfg_pkg::tag_t   rd_tag2,
    input  window_cfg_pkg::data_t  rd_data1,
    input  window_cfg_pkg::data_t  rd_data2,
    output logic                   result_valid,
    output window_cfg_pkg::tag_t   result_tag,
    output window_cfg_pkg::data_t  result_value
);

    import window_cfg_pkg::*;
    import alu_ops_pkg::*;

    localparam int idx_w = (num_entries > 1) ? $clog2(num_entries) : 1;

    logic [idx_w-1:0] sel;
    alu_op_t          sel_op;
    src2_u            sel_src2;
    data_t            opa;
    data_t            opb;
    data_t            alu_out;

    // lowest requesting entry wins
    assign grant = request & (~request + 1'b1);

    always_comb begin
        sel = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (grant[i]) begin
                sel = idx_w'(i);
            end
        end
    end

    assign sel_op   = op[sel];
    assign sel_src2 = src2[sel];

    assign rd_tag1 = src1[sel];
    assign rd_tag2 = sel_src2.rf.tag;

    assign opa = rd_data1;
    assign opb = src2_is_imm[sel] ? sel_src2.imm : rd_data2;

    always_comb begin
        case (sel_op)
            alu_add:    alu_out = opa + opb;
            alu_sub:    alu_out = opa - opb;
            alu_and:    alu_out = opa & opb;
            alu_or:     alu_out = opa | opb;
            alu_xor:    alu_out = opa ^ opb;
            alu_sll:    alu_out = opa << opb[4:0];
            alu_srl:    alu_out = opa >> opb[4:0];
            alu_sra:    alu_out = $signed(opa) >>> opb[4:0];
            alu_slt:    alu_out = {31'd0, $signed(opa) < $signed(opb)};
            alu_sltu:   alu_out = {31'd0, opa < opb};
            alu_pass_b: alu_out = opb;
            default:    alu_out = '0;
        endcase
    end

    // broadcast register, also the write-back port
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= |request;
        end
    end

    always_ff @(posedge clk) begin
        result_tag   <= dest[sel];
        result_value <= alu_out;
    end

    // a granted entry has freed itself and cannot issue twice
    a_no_reissue: assert property (
        @(posedge clk) disable iff (reset) (grant != '0) |=> ((request & $past(grant)) == '0)
    );

endmodule

//--- verilog/phys_reg_file.sv
`timescale 1ns/1ns

module phys_reg_file #(
    parameter int num_phys = 64
) (
    input  logic                  clk,
    input  logic                  reset,
    input  window_cfg_pkg::tag_t  rd_tag1,
    input  window_cfg_pkg::tag_t  rd_tag2,
    output window_cfg_pkg::data_t rd_data1,
    output window_cfg_pkg::data_t rd_data2,
    input  window_cfg_pkg::tag_t  rdy_tag1,
    input  window_cfg_pkg::tag_t  rdy_tag2,
    output logic                  src1_ready,
    output logic                  src2_ready,
    input  logic                  clear_ready,
    input  window_cfg_pkg::tag_t  clear_tag,
    input  logic                  wr_valid,
    input  window_cfg_pkg::tag_t  wr_tag,
    input  window_cfg_pkg::data_t wr_data
);

    import window_cfg_pkg::*;

    data_t               regs [num_phys];
    logic [num_phys-1:0] ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= '1; // every tag starts committed
            for (int i = 0; i < num_phys; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_valid) begin
                regs[wr_tag]  <= wr_data;
                ready[wr_tag] <= 1'b1;
            end
            // a new producer on the same tag wins over write-back
            if (clear_ready) begin
                ready[clear_tag] <= 1'b0;
            end
        end
    end

    assign rd_data1 = regs[rd_tag1];
    assign rd_data2 = regs[rd_tag2];

    assign src1_ready = ready[rdy_tag1];
    assign src2_ready = ready[rdy_tag2];

    // write-back only lands on a tag left pending by a dispatch
    a_wr_pending: assert property (
        @(posedge clk) disable iff (reset) wr_valid |-> !ready[wr_tag]
    );

endmodule

//--- verilog/issue_window_top.sv
`timescale 1ns/1ns

module issue_window_top #(
    parameter int num_entries = 8,
    parameter int num_phys    = 64
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  alu_ops_pkg::alu_op_t  dispatch_op,
    input  window_cfg_pkg::tag_t  dispatch_dest,
    input  window_cfg_pkg::tag_t  dispatch_src1,
    input  alu_ops_pkg::src2_u    dispatch_src2,
    input  logic                  dispatch_src2_is_imm,
    output logic                  window_full,
    output logic                  result_valid,
    output window_cfg_pkg::tag_t  result_tag,
    output window_cfg_pkg::data_t result_value
);

    import window_cfg_pkg::*;
    import alu_ops_pkg::*;

    // dispatch side
    tag_t                   rdy_tag1;
    tag_t                   rdy_tag2;
    logic                   src1_ready;
    logic                   src2_ready;
    logic                   clear_ready;
    logic [num_entries-1:0] fill_sel;
    alu_op_t                fill_op;
    tag_t                   fill_dest;
    tag_t                   fill_src1;
    src2_u                  fill_src2;
    logic                   fill_src2_is_imm;
    logic                   fill_rdy1;
    logic                   fill_rdy2;

    // entry outputs toward select
    logic [num_entries-1:0] entry_busy;
    logic [num_entries-1:0] entry_request;
    logic [num_entries-1:0] grant;
    alu_op_t                ent_op [num_entries];
    tag_t                   ent_dest [num_entries];
    tag_t                   ent_src1 [num_entries];
    src2_u                  ent_src2 [num_entries];
    logic [num_entries-1:0] ent_src2_is_imm;

    // operand read for the granted entry
    tag_t                   rd_tag1;
    tag_t                   rd_tag2;
    data_t                  rd_data1;
    data_t                  rd_data2;

    dispatch_unit #(
        .num_entries(num_entries)
    ) u_dispatch_unit (
        .clk(clk),
        .reset(reset),
        .dispatch_valid(dispatch_valid),
        .dispatch_op(dispatch_op),
        .dispatch_dest(dispatch_dest),
        .dispatch_src1(dispatch_src1),
        .dispatch_src2(dispatch_src2),
        .dispatch_src2_is_imm(dispatch_src2_is_imm),
        .src1_ready(src1_ready),
        .src2_ready(src2_ready),
        .result_valid(result_valid),
        .result_tag(result_tag),
        .entry_busy(entry_busy),
        .rd_tag1(rdy_tag1),
        .rd_tag2(rdy_tag2),
        .clear_ready(clear_ready),
        .fill_sel(fill_sel),
        .fill_op(fill_op),
        .fill_dest(fill_dest),
        .fill_src1(fill_src1),
        .fill_src2(fill_src2),
        .fill_src2_is_imm(fill_src2_is_imm),
        .fill_rdy1(fill_rdy1),
        .fill_rdy2(fill_rdy2),
        .window_full(window_full)
    );

    for (genvar i = 0; i < num_entries; i++) begin : g_entry
        rs_entry u_rs_entry (
            .clk(clk),
            .reset(reset),
            .fill(fill_sel[i]),
            .fill_op(fill_op),
            .fill_dest(fill_dest),
            .fill_src1(fill_src1),
            .fill_src2(fill_src2),
            .fill_src2_is_imm(fill_src2_is_imm),
            .fill_rdy1(fill_rdy1),
            .fill_rdy2(fill_rdy2),
            .result_valid(result_valid),
            .result_tag(result_tag),
            .grant(grant[i]),
            .busy(entry_busy[i]),
            .request(entry_request[i]),
            .op(ent_op[i]),
            .dest(ent_dest[i]),
            .src1(ent_src1[i]),
            .src2(ent_src2[i]),
            .src2_is_imm(ent_src2_is_imm[i])
        );
    end

    issue_select #(
        .num_entries(num_entries)
    ) u_issue_select (
        .clk(clk),
        .reset(reset),
        .request(entry_request),
        .op(ent_op),
        .dest(ent_dest),
        .src1(ent_src1),
        .src2(ent_src2),
        .src2_is_imm(ent_src2_is_imm),
        .grant(grant),
        .rd_tag1(rd_tag1),
        .rd_tag2(rd_tag2),
        .rd_data1(rd_data1),
        .rd_data2(rd_data2),
        .result_valid(result_valid),
        .result_tag(result_tag),
        .result_value(result_value)
    );

    phys_reg_file #(
        .num_phys(num_phys)
    ) u_phys_reg_file (
        .clk(clk),
        .reset(reset),
        .rd_tag1(rd_tag1),
        .rd_tag2(rd_tag2),
        .rd_data1(rd_data1),
        .rd_data2(rd_data2),
        .rdy_tag1(rdy_tag1),
        .rdy_tag2(rdy_tag2),
        .src1_ready(src1_ready),
        .src2_ready(src2_ready),
        .clear_ready(clear_ready),
        .clear_tag(fill_dest),
        .wr_valid(result_valid),
        .wr_tag(result_tag),
        .wr_data(result_value)
    );

endmodule

//--- sim/tb_issue_window.sv
`timescale 1ns/1ns

module tb_issue_window;

    import window_cfg_pkg::*;
    import alu_ops_pkg::*;

    localparam int num_entries = 8;
    localparam int num_phys    = 64;
    localparam int max_pats    = 64;
    localparam int fields      = 6; // op dest src1 src2 is_imm expected

    logic        clk;
    logic        reset;
    logic        dispatch_valid;
    alu_op_t     dispatch_op;
    tag_t        dispatch_dest;
    tag_t        dispatch_src1;
    src2_u       dispatch_src2;
    logic        dispatch_src2_is_imm;
    logic        window_full;
    logic        result_valid;
    tag_t        result_tag;
    data_t       result_value;

    logic [31:0] pat_mem [max_pats*fields];
    data_t       expected [num_phys];
    int          issue_count [num_phys];
    int          seen_count [num_phys];
    int          pat_of_tag [num_phys];
    int          num_pats;
    int          results_seen;
    int          full_waits;
    logic [31:0] lfsr;

    issue_window_top #(
        .num_entries(num_entries),
        .num_phys(num_phys)
    ) i_issue_window_top (
        .clk(clk),
        .reset(reset),
        .dispatch_valid(dispatch_valid),
        .dispatch_op(dispatch_op),
        .dispatch_dest(dispatch_dest),
        .dispatch_src1(dispatch_src1),
        .dispatch_src2(dispatch_src2),
        .dispatch_src2_is_imm(dispatch_src2_is_imm),
        .window_full(window_full),
        .result_valid(result_valid),
        .result_tag(result_tag),
        .result_value(result_value)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_equal(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic dispatch_pattern(input int idx);
        int   base;
        tag_t dest;
        base = idx * fields;
        dest = pat_mem[base+1][tag_width-1:0];
        // hold off while full, or while dest still has a result in flight
        while (window_full || issue_count[dest] != seen_count[dest]) begin
            if (window_full) begin
                full_waits++;
            end
            @(negedge clk);
        end
        dispatch_op          = alu_op_t'(pat_mem[base][3:0]);
        dispatch_dest        = dest;
        dispatch_src1        = pat_mem[base+2][tag_width-1:0];
        dispatch_src2.imm    = pat_mem[base+3]; // tag in the low bits for register ops
        dispatch_src2_is_imm = pat_mem[base+4][0];
        expected[dest]       = pat_mem[base+5];
        pat_of_tag[dest]     = idx;
        issue_count[dest]++;
        dispatch_valid = 1'b1;
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    // broadcast monitor, outputs are registered so the falling edge is quiet
    always @(negedge clk) begin
        if (!reset && result_valid) begin
            if (seen_count[result_tag] >= issue_count[result_tag]) begin
                fail_run($sformatf("result broadcast on tag %0d with no operation in flight",
                                   result_tag));
            end else begin
                check_equal($sformatf("pattern %0d tag %0d", pat_of_tag[result_tag], result_tag),
                            expected[result_tag], result_value);
                seen_count[result_tag]++;
                results_seen++;
            end
        end
    end

    initial begin
        wait (num_pats > 0);
        repeat (num_pats * 40 + 200) @(posedge clk);
        fail_run("watchdog expired with results still outstanding");
    end

    initial begin
        int gap;
        clk                  = 1'b0;
        reset                = 1'b1;
        dispatch_valid       = 1'b0;
        dispatch_op          = alu_add;
        dispatch_dest        = '0;
        dispatch_src1        = '0;
        dispatch_src2        = '0;
        dispatch_src2_is_imm = 1'b0;
        lfsr                 = 32'hf7c7;
        num_pats             = 0;
        full_waits           = 0;

        for (int i = 0; i < max_pats * fields; i++) begin
            pat_mem[i] = '1; // all ones op marks the end
        end
        $readmemh("sim/alu_patterns.txt", pat_mem);
        while (num_pats < max_pats && pat_mem[num_pats*fields] != 32'hffff_ffff) begin
            num_pats++;
        end
        if (num_pats == 0) begin
            fail_run("no patterns loaded from sim/alu_patterns.txt");
        end

        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_equal("reset result_valid", 32'd0, data_t'(result_valid));
            check_equal("reset window_full", 32'd0, data_t'(window_full));
        end
        reset = 1'b0;
        @(negedge clk);
        check_equal("post reset result_valid", 32'd0, data_t'(result_valid));
        check_equal("post reset window_full", 32'd0, data_t'(window_full));

        for (int i = 0; i < num_pats; i++) begin
            gap = draw_bits(3);
            if (gap > 5) begin
                repeat (gap - 5) @(negedge clk); // mostly back to back
            end
            dispatch_pattern(i);
        end

        // missing results end in the watchdog, extra ones in the monitor
        while (results_seen < num_pats) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk); // window for a stray broadcast

        $display("patterns %0d results %0d cycles held by full window %0d",
                 num_pats, results_seen, full_waits);
        $display("Test passed");
        $finish;
    end

endmodule

//--- sim/alu_patterns.txt
// columns: op dest src1 src2 is_imm expected, all hex, src2 is a tag when is_imm is 0
// op: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 sra 8 slt 9 sltu a pass_b
a 01 00 12345678 1 12345678
a 02 00 0000000f 1 0000000f
a 03 00 80000000 1 80000000
a 04 00 fffffff0 1 fffffff0
a 05 00 00000004 1 00000004
0 06 00 00000064 1 00000064
a 07 00 0f0f0f0f 1 0f0f0f0f
0 08 01 00000002 0 12345687
1 09 02 00000001 0 edcba997
2 0a 01 00000007 0 02040608
3 0b 01 00000007 0 1f3f5f7f
4 0c 01 00000007 0 1d3b5977
5 0d 01 00000005 0 23456780
6 0e 03 00000005 0 08000000
7 0f 03 00000005 0 f8000000
7 10 04 00000005 0 ffffffff
8 11 04 00000002 0 00000001
9 12 04 00000002 0 00000000
a 15 00 00000001 0 12345678
5 16 02 00000024 1 000000f0
0 18 02 00000001 1 00000010
0 19 18 00000018 0 00000020
1 1a 19 00000003 1 0000001d
4 1b 1a 00000007 0 0f0f0f12
5 1c 1b 00000008 1 0f0f1200
3 1d 1c 00000002 0 0f0f120f
6 1e 1d 00000004 1 00f0f120
0 1f 1e 00000001 0 13254798
2 20 1f 00000007 0 03050708
7 21 20 00000001 1 01828384
0 22 21 00000001 1 01828385
1 23 21 00000021 0 00000000
8 24 21 00000004 0 00000000
9 25 21 00000004 0 00000001
4 26 21 ffffffff 1 fe7d7c7b
a 27 00 00000021 0 01828384
5 28 05 00000021 0 00000040
6 29 21 00000005 0 00182838

//--- sources.f
common/window_cfg_pkg.sv
common/alu_ops_pkg.sv
issue_window/dispatch_unit.sv
issue_window/rs_entry.sv
issue_window/issue_select.sv
verilog/phys_reg_file.sv
verilog/issue_window_top.sv
sim/tb_issue_window.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_issue_window -f sources.f \
    && ./obj_dir/Vtb_issue_window \
    || exit 1
